// ==== Makefile ====
TOP = cpu_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [4:0]               i_op,
	input  logic [cpu_pkg::XLEN-1:0] i_a,
	input  logic [cpu_pkg::XLEN-1:0] i_b,
	output logic [cpu_pkg::XLEN-1:0] o_result,
	output logic                     o_is_false
);
	import cpu_pkg::*;

	logic a_true;
	logic b_true;
	logic b_zero;	// Guards divide and modulo

	assign a_true = (i_a != '0);
	assign b_true = (i_b != '0);
	assign b_zero = ~b_true;

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_MUL: o_result = i_a * i_b;	// Low word only
			ALU_DIV: o_result = b_zero ? '0 : i_a / i_b;
			ALU_MOD: o_result = b_zero ? '0 : i_a % i_b;
			ALU_SLL: o_result = i_a << i_b[4:0];
			ALU_SRL: o_result = i_a >> i_b[4:0];

			ALU_AND:  o_result = i_a & i_b;
			ALU_OR:   o_result = i_a | i_b;
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_NOT:  o_result = ~i_a;
			ALU_LAND: o_result = XLEN'(a_true & b_true);
			ALU_LOR:  o_result = XLEN'(a_true | b_true);

			ALU_PASSA: o_result = i_a;
			ALU_PASSB: o_result = i_b;

			// Compares are unsigned and give 1 or 0
			ALU_EQ:  o_result = XLEN'(i_a == i_b);
			ALU_NE:  o_result = XLEN'(i_a != i_b);
			ALU_LT:  o_result = XLEN'(i_a < i_b);
			ALU_LET: o_result = XLEN'(i_a <= i_b);
			ALU_GT:  o_result = XLEN'(i_a > i_b);
			ALU_GET: o_result = XLEN'(i_a >= i_b);
			default: o_result = '0;
		endcase
	end

	assign o_is_false = (o_result == '0);	// jf condition

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  cpu_pkg::instr_u i_instr,
	output cpu_pkg::ctrl_t  o_ctrl
);
	import cpu_pkg::*;

	logic [4:0] imm_alu_op;	// ALU code of the I-type ALU forms
	logic [4:0] fn_alu_op;	// ALU code of the R-type forms

	always_comb begin
		case (i_instr.i.op)
			OP_ADDI:  imm_alu_op = ALU_ADD;
			OP_SUBI:  imm_alu_op = ALU_SUB;
			OP_MULI:  imm_alu_op = ALU_MUL;
			OP_DIVI:  imm_alu_op = ALU_DIV;
			OP_MODI:  imm_alu_op = ALU_MOD;
			OP_ANDI:  imm_alu_op = ALU_AND;
			OP_ORI:   imm_alu_op = ALU_OR;
			OP_XORI:  imm_alu_op = ALU_XOR;
			OP_NOT:   imm_alu_op = ALU_NOT;
			OP_LANDI: imm_alu_op = ALU_LAND;
			OP_LORI:  imm_alu_op = ALU_LOR;
			OP_SLLI:  imm_alu_op = ALU_SLL;
			OP_SRLI:  imm_alu_op = ALU_SRL;
			OP_MOV:   imm_alu_op = ALU_PASSA;
			OP_LI:    imm_alu_op = ALU_PASSB;
			default:  imm_alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (i_instr.r.fn)
			FN_SUB:  fn_alu_op = ALU_SUB;
			FN_MUL:  fn_alu_op = ALU_MUL;
			FN_DIV:  fn_alu_op = ALU_DIV;
			FN_MOD:  fn_alu_op = ALU_MOD;
			FN_AND:  fn_alu_op = ALU_AND;
			FN_OR:   fn_alu_op = ALU_OR;
			FN_XOR:  fn_alu_op = ALU_XOR;
			FN_LAND: fn_alu_op = ALU_LAND;
			FN_LOR:  fn_alu_op = ALU_LOR;
			FN_SLL:  fn_alu_op = ALU_SLL;
			FN_SRL:  fn_alu_op = ALU_SRL;
			FN_EQ:   fn_alu_op = ALU_EQ;
			FN_NE:   fn_alu_op = ALU_NE;
			FN_LT:   fn_alu_op = ALU_LT;
			FN_LET:  fn_alu_op = ALU_LET;
			FN_GT:   fn_alu_op = ALU_GT;
			FN_GET:  fn_alu_op = ALU_GET;
			FN_JR:   fn_alu_op = ALU_PASSA;	// Return address is rs
			default: fn_alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		o_ctrl = '0;	// Anything not listed is a no-op
		case (i_instr.r.op)
			OP_RTYPE: begin
				o_ctrl.alu_op = fn_alu_op;
				if (i_instr.r.fn == FN_JR) begin
					o_ctrl.pc_source = PC_REG;
				end else if (i_instr.r.fn <= FN_GET) begin
					o_ctrl.reg_write     = 1'b1;
					o_ctrl.is_reg_alu_op = 1'b1;
				end else begin
					o_ctrl = '0;	// Undefined function
				end
			end
			OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI, OP_ORI,
			OP_XORI, OP_NOT, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI, OP_MOV,
			OP_LI: begin
				o_ctrl.reg_write  = 1'b1;
				o_ctrl.is_rt_dest = 1'b1;
				o_ctrl.alu_op     = imm_alu_op;
			end
			OP_LW: begin
				o_ctrl.reg_write  = 1'b1;
				o_ctrl.is_rt_dest = 1'b1;
				o_ctrl.wb_select  = WB_MEM;
			end
			OP_SW: o_ctrl.mem_write = 1'b1;
			OP_IN: begin
				o_ctrl.reg_write  = 1'b1;
				o_ctrl.is_rt_dest = 1'b1;
				o_ctrl.wb_select  = WB_IN;
			end
			OP_OUT: begin
				o_ctrl.out_write     = 1'b1;
				o_ctrl.is_reg_alu_op = 1'b1;
				o_ctrl.alu_op        = ALU_PASSB;
			end
			OP_JF: begin
				// Taken only when the tested register reads zero
				o_ctrl.is_jf         = 1'b1;
				o_ctrl.is_reg_alu_op = 1'b1;
				o_ctrl.pc_source     = PC_BRANCH;
				o_ctrl.alu_op        = ALU_PASSB;
			end
			OP_J: o_ctrl.pc_source = PC_JUMP;
			OP_JAL: begin
				o_ctrl.reg_write = 1'b1;
				o_ctrl.pc_source = PC_JUMP;
				o_ctrl.wb_select = WB_LINK;
			end
			OP_HALT: o_ctrl.is_halt = 1'b1;
			default: o_ctrl = '0;
		endcase
	end

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic [31:0]              i_instr,
	input  logic [cpu_pkg::XLEN-1:0] i_mem_rdata,
	input  logic [cpu_pkg::XLEN-1:0] i_in_data,
	output logic [cpu_pkg::XLEN-1:0] o_pc,
	output logic                     o_mem_we,
	output logic [cpu_pkg::XLEN-1:0] o_mem_addr,
	output logic [cpu_pkg::XLEN-1:0] o_mem_wdata,
	output logic                     o_out_valid,
	output logic [cpu_pkg::XLEN-1:0] o_out_data,
	output logic                     o_halted
);
	import cpu_pkg::*;

	instr_u            instr;
	ctrl_t             ctrl;
	logic [REG_AW-1:0] rf_waddr;
	logic [REG_AW-1:0] rf_raddr_b;
	logic [XLEN-1:0]   rf_wdata;
	logic [XLEN-1:0]   rf_rdata_a;	// rs
	logic [XLEN-1:0]   rf_rdata_b;
	logic [XLEN-1:0]   imm_ext;
	logic [XLEN-1:0]   alu_b;
	logic [XLEN-1:0]   alu_result;
	logic              alu_is_false;
	logic              rf_we;

	assign instr   = i_instr;
	assign imm_ext = {{(XLEN-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};

	control_unit ctrl0 (.i_instr(instr), .o_ctrl(ctrl));

	// out and jf pass rs through the b side, everything else reads rt there
	assign rf_raddr_b = (ctrl.out_write | ctrl.is_jf) ? instr.i.rs : instr.i.rt;

	always_comb begin
		if (ctrl.wb_select == WB_LINK)
			rf_waddr = REG_LINK;
		else
			rf_waddr = ctrl.is_rt_dest ? instr.i.rt : instr.r.rd;
	end

	always_comb begin
		case (ctrl.wb_select)
			WB_MEM:  rf_wdata = i_mem_rdata;	// Same-cycle load data
			WB_IN:   rf_wdata = i_in_data;
			WB_LINK: rf_wdata = o_pc + 1'b1;
			default: rf_wdata = alu_result;
		endcase
	end

	assign rf_we = ctrl.reg_write & ~o_halted;

	register_file rf0 (
		.i_clk(i_clk), .i_rst(i_rst), .i_we(rf_we), .i_waddr(rf_waddr), .i_wdata(rf_wdata),
		.i_raddr_a(instr.i.rs), .i_raddr_b(rf_raddr_b),
		.o_rdata_a(rf_rdata_a), .o_rdata_b(rf_rdata_b)
	);

	assign alu_b = ctrl.is_reg_alu_op ? rf_rdata_b : imm_ext;

	alu alu0 (
		.i_op(ctrl.alu_op), .i_a(rf_rdata_a), .i_b(alu_b),
		.o_result(alu_result), .o_is_false(alu_is_false)
	);

	pc_unit pc0 (
		.i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl), .i_is_false(alu_is_false),
		.i_imm(instr.i.imm), .i_target(instr.j.target), .i_reg_target(alu_result),
		.o_pc(o_pc), .o_halted(o_halted)
	);

	assign o_mem_addr  = rf_rdata_a + imm_ext;	// Shared by lw and sw
	assign o_mem_wdata = rf_rdata_b;
	assign o_mem_we    = ctrl.mem_write & ~o_halted;
	assign o_out_valid = ctrl.out_write & ~o_halted;
	assign o_out_data  = alu_result;

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN    = 32;	// Data word width
	localparam int REG_AW  = 5;		// Register address width
	localparam int IMM_W   = 16;
	localparam int JADDR_W = 26;	// Jump target width

	localparam logic [REG_AW-1:0] REG_LINK = 5'd31;	// jal writes its return address here

	// Opcodes
	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_ADDI  = 6'd1;
	localparam logic [5:0] OP_SUBI  = 6'd2;
	localparam logic [5:0] OP_MULI  = 6'd3;
	localparam logic [5:0] OP_DIVI  = 6'd4;
	localparam logic [5:0] OP_MODI  = 6'd5;
	localparam logic [5:0] OP_ANDI  = 6'd6;
	localparam logic [5:0] OP_ORI   = 6'd7;
	localparam logic [5:0] OP_XORI  = 6'd8;
	localparam logic [5:0] OP_NOT   = 6'd9;
	localparam logic [5:0] OP_LANDI = 6'd10;
	localparam logic [5:0] OP_LORI  = 6'd11;
	localparam logic [5:0] OP_SLLI  = 6'd12;
	localparam logic [5:0] OP_SRLI  = 6'd13;
	localparam logic [5:0] OP_MOV   = 6'd14;
	localparam logic [5:0] OP_LW    = 6'd15;
	localparam logic [5:0] OP_LI    = 6'd16;
	localparam logic [5:0] OP_SW    = 6'd18;
	localparam logic [5:0] OP_IN    = 6'd19;
	localparam logic [5:0] OP_OUT   = 6'd20;
	localparam logic [5:0] OP_JF    = 6'd21;
	localparam logic [5:0] OP_J     = 6'd60;
	localparam logic [5:0] OP_JAL   = 6'd62;
	localparam logic [5:0] OP_HALT  = 6'd63;

	// R-type function field
	localparam logic [5:0] FN_ADD  = 6'd0;
	localparam logic [5:0] FN_SUB  = 6'd1;
	localparam logic [5:0] FN_MUL  = 6'd2;
	localparam logic [5:0] FN_DIV  = 6'd3;
	localparam logic [5:0] FN_MOD  = 6'd4;
	localparam logic [5:0] FN_AND  = 6'd5;
	localparam logic [5:0] FN_OR   = 6'd6;
	localparam logic [5:0] FN_XOR  = 6'd7;
	localparam logic [5:0] FN_LAND = 6'd8;
	localparam logic [5:0] FN_LOR  = 6'd9;
	localparam logic [5:0] FN_SLL  = 6'd10;
	localparam logic [5:0] FN_SRL  = 6'd11;
	localparam logic [5:0] FN_EQ   = 6'd12;
	localparam logic [5:0] FN_NE   = 6'd13;
	localparam logic [5:0] FN_LT   = 6'd14;
	localparam logic [5:0] FN_LET  = 6'd15;
	localparam logic [5:0] FN_GT   = 6'd16;
	localparam logic [5:0] FN_GET  = 6'd17;
	localparam logic [5:0] FN_JR   = 6'd18;

	// ALU operations, bit 4 marks the compares
	localparam logic [4:0] ALU_ADD   = 5'd0;
	localparam logic [4:0] ALU_SUB   = 5'd1;
	localparam logic [4:0] ALU_MUL   = 5'd2;
	localparam logic [4:0] ALU_DIV   = 5'd3;
	localparam logic [4:0] ALU_MOD   = 5'd4;
	localparam logic [4:0] ALU_SLL   = 5'd5;
	localparam logic [4:0] ALU_SRL   = 5'd6;
	localparam logic [4:0] ALU_AND   = 5'd8;
	localparam logic [4:0] ALU_OR    = 5'd9;
	localparam logic [4:0] ALU_XOR   = 5'd10;
	localparam logic [4:0] ALU_NOT   = 5'd11;
	localparam logic [4:0] ALU_LAND  = 5'd12;
	localparam logic [4:0] ALU_LOR   = 5'd13;
	localparam logic [4:0] ALU_PASSA = 5'd14;
	localparam logic [4:0] ALU_PASSB = 5'd15;
	localparam logic [4:0] ALU_EQ    = 5'd16;
	localparam logic [4:0] ALU_NE    = 5'd17;
	localparam logic [4:0] ALU_LT    = 5'd18;
	localparam logic [4:0] ALU_LET   = 5'd19;
	localparam logic [4:0] ALU_GT    = 5'd20;
	localparam logic [4:0] ALU_GET   = 5'd21;

	// Next-PC sources
	localparam logic [1:0] PC_SEQ    = 2'd0;
	localparam logic [1:0] PC_BRANCH = 2'd1;
	localparam logic [1:0] PC_REG    = 2'd2;
	localparam logic [1:0] PC_JUMP   = 2'd3;

	// Write-back sources
	localparam logic [1:0] WB_ALU  = 2'd0;
	localparam logic [1:0] WB_MEM  = 2'd1;
	localparam logic [1:0] WB_IN   = 2'd2;
	localparam logic [1:0] WB_LINK = 2'd3;	// PC plus one

	typedef struct packed {
		logic [5:0]        op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		logic [4:0]        unused;
		logic [5:0]        fn;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]        op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [IMM_W-1:0]  imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]         op;
		logic [JADDR_W-1:0] target;
	} j_fields_t;

	// One instruction word, three field layouts
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_u;

	typedef struct packed {
		logic       reg_write;
		logic       mem_write;
		logic       is_reg_alu_op;	// b operand from register, else immediate
		logic       is_rt_dest;
		logic       out_write;
		logic       is_halt;
		logic       is_jf;
		logic [1:0] pc_source;
		logic [1:0] wb_select;
		logic [4:0] alu_op;
	} ctrl_t;

endpackage

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  cpu_pkg::ctrl_t              i_ctrl,
	input  logic                        i_is_false,
	input  logic [cpu_pkg::IMM_W-1:0]   i_imm,
	input  logic [cpu_pkg::JADDR_W-1:0] i_target,
	input  logic [cpu_pkg::XLEN-1:0]    i_reg_target,
	output logic [cpu_pkg::XLEN-1:0]    o_pc,
	output logic                        o_halted
);
	import cpu_pkg::*;

	logic [XLEN-1:0] pc_plus_one;
	logic [XLEN-1:0] next_pc;

	assign pc_plus_one = o_pc + 1'b1;

	always_comb begin
		case (i_ctrl.pc_source)
			PC_BRANCH: next_pc = (i_ctrl.is_jf & i_is_false) ?
				{{(XLEN-IMM_W){1'b0}}, i_imm} : pc_plus_one;	// Absolute word address
			PC_REG:    next_pc = i_reg_target;	// jr
			PC_JUMP:   next_pc = {{(XLEN-JADDR_W){1'b0}}, i_target};
			default:   next_pc = pc_plus_one;
		endcase
	end

	// The halt instruction itself keeps the PC, so o_pc stays on it
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_pc     <= '0;
			o_halted <= 1'b0;
		end else if (!o_halted) begin
			if (i_ctrl.is_halt)
				o_halted <= 1'b1;
			else
				o_pc <= next_pc;
		end
	end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_we,
	input  logic [cpu_pkg::REG_AW-1:0] i_waddr,
	input  logic [cpu_pkg::XLEN-1:0]   i_wdata,
	input  logic [cpu_pkg::REG_AW-1:0] i_raddr_a,
	input  logic [cpu_pkg::REG_AW-1:0] i_raddr_b,
	output logic [cpu_pkg::XLEN-1:0]   o_rdata_a,
	output logic [cpu_pkg::XLEN-1:0]   o_rdata_b
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [0:(1 << REG_AW)-1];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int k = 0; k < (1 << REG_AW); k++) begin
				regs[k] <= '0;
			end
		end else if (i_we && (i_waddr != '0)) begin	// r0 stays zero
			regs[i_waddr] <= i_wdata;
		end
	end

	// Asynchronous reads, no write bypass
	assign o_rdata_a = regs[i_raddr_a];
	assign o_rdata_b = regs[i_raddr_b];

endmodule

// ==== testbench/cpu_core_props.sv ====
`timescale 1ns/1ps

module cpu_core_props (
	input logic                     i_clk,
	input logic                     i_rst,
	input logic [cpu_pkg::XLEN-1:0] i_pc,
	input logic                     i_halted,
	input logic                     i_mem_we,
	input logic                     i_out_valid
);
	int unsigned fail_count = 0;	// Read by the testbench at the end

	pc_zero_after_reset: assert property (@(posedge i_clk) i_rst |=> i_pc == '0)
		else begin
			fail_count++;
			$error("PC is not zero in the cycle after reset");
		end

	pc_frozen_when_halted: assert property (
		@(posedge i_clk) disable iff (i_rst) i_halted |=> $stable(i_pc))
		else begin
			fail_count++;
			$error("PC moved while halted");
		end

	no_strobe_when_halted: assert property (
		@(posedge i_clk) disable iff (i_rst) i_halted |-> !i_mem_we && !i_out_valid)
		else begin
			fail_count++;
			$error("Write strobe raised while halted");
		end

	strobes_exclusive: assert property (
		@(posedge i_clk) disable iff (i_rst) !(i_mem_we && i_out_valid))
		else begin
			fail_count++;
			$error("Memory write and out strobe high together");
		end

endmodule

bind cpu_core cpu_core_props props0 (
	.i_clk(i_clk), .i_rst(i_rst), .i_pc(o_pc), .i_halted(o_halted),
	.i_mem_we(o_mem_we), .i_out_valid(o_out_valid)
);

// ==== testbench/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;
	import cpu_pkg::*;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		instr_u          instr;
		logic            is_out;	// Expect an out strobe
		logic            is_store;
		logic            from_in;	// Out shows the value captured by in
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] value;
	} step_t;

	logic            i_clk;
	logic            i_rst;
	logic [31:0]     i_instr;
	logic [XLEN-1:0] i_mem_rdata;
	logic [XLEN-1:0] i_in_data;
	logic [XLEN-1:0] o_pc;
	logic            o_mem_we;
	logic [XLEN-1:0] o_mem_addr;
	logic [XLEN-1:0] o_mem_wdata;
	logic            o_out_valid;
	logic [XLEN-1:0] o_out_data;
	logic            o_halted;

	step_t           steps [$];
	logic [31:0]     prog [0:255];
	logic [XLEN-1:0] dmem [0:63];
	logic [XLEN-1:0] rand_state;
	logic [XLEN-1:0] in_seen;
	logic [XLEN-1:0] halt_pc;
	logic [XLEN-1:0] a_val;	// Held in r1
	logic [XLEN-1:0] b_val;	// Held in r2
	int              at;
	int              errors;
	int              checks;
	int              cycles;
	int              limit;
	int              waited;

	cpu_core dut0 (.*);

	assign i_mem_rdata = dmem[o_mem_addr[5:0]];	// Load data in the same cycle

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// Instruction encoders, destination register first
	function automatic instr_u rtype(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		rtype = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instr_u itype(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		itype = {op, rs, rt, imm};
	endfunction

	function automatic instr_u jtype(input logic [5:0] op, input logic [25:0] target);
		jtype = {op, target};
	endfunction

	function automatic logic [XLEN-1:0] lcg(input logic [XLEN-1:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic push(input instr_u ins, input logic out_f, input logic store_f,
			input logic from_in, input logic [XLEN-1:0] addr, input logic [XLEN-1:0] value);
		step_t st;
		st = '0;
		st.pc       = at;
		st.instr    = ins;
		st.is_out   = out_f;
		st.is_store = store_f;
		st.from_in  = from_in;
		st.addr     = addr;
		st.value    = value;
		steps.push_back(st);
		at = at + 1;
	endtask

	task automatic plain(input instr_u ins);
		push(ins, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic show(input logic [4:0] r, input logic [XLEN-1:0] exp);
		push(itype(OP_OUT, 5'd0, r, 16'd0), 1'b1, 1'b0, 1'b0, '0, exp);
	endtask

	task automatic alu_check(input instr_u ins, input logic [XLEN-1:0] exp);
		plain(ins);	// Result lands in r3
		show(5'd3, exp);
	endtask

	task automatic build_program;
		at = 0;
		plain(itype(OP_LI, 5'd1, 5'd0, a_val[15:0]));
		plain(itype(OP_LI, 5'd2, 5'd0, b_val[15:0]));
		show(5'd1, a_val);
		alu_check(itype(OP_ADDI, 5'd3, 5'd1, 16'hFFFB), a_val - 32'd5);	// Sign-extended
		alu_check(rtype(FN_ADD, 5'd3, 5'd1, 5'd2), a_val + b_val);
		alu_check(rtype(FN_SUB, 5'd3, 5'd2, 5'd1), b_val - a_val);
		alu_check(rtype(FN_MUL, 5'd3, 5'd1, 5'd2), a_val * b_val);
		alu_check(rtype(FN_DIV, 5'd3, 5'd1, 5'd2), a_val / b_val);
		alu_check(rtype(FN_MOD, 5'd3, 5'd1, 5'd2), a_val % b_val);
		alu_check(rtype(FN_DIV, 5'd3, 5'd1, 5'd0), 32'd0);	// Divide by zero
		alu_check(rtype(FN_AND, 5'd3, 5'd1, 5'd2), a_val & b_val);
		alu_check(rtype(FN_OR, 5'd3, 5'd1, 5'd2), a_val | b_val);
		alu_check(rtype(FN_XOR, 5'd3, 5'd1, 5'd2), a_val ^ b_val);
		alu_check(itype(OP_NOT, 5'd3, 5'd1, 16'd0), ~a_val);
		alu_check(rtype(FN_SLL, 5'd3, 5'd1, 5'd2), a_val << 7);
		alu_check(rtype(FN_SRL, 5'd3, 5'd1, 5'd2), a_val >> 7);
		alu_check(rtype(FN_EQ, 5'd3, 5'd1, 5'd2), {31'd0, a_val == b_val});
		alu_check(rtype(FN_NE, 5'd3, 5'd1, 5'd2), {31'd0, a_val != b_val});
		alu_check(rtype(FN_LT, 5'd3, 5'd2, 5'd1), {31'd0, b_val < a_val});
		alu_check(rtype(FN_LET, 5'd3, 5'd1, 5'd1), {31'd0, a_val <= a_val});
		alu_check(rtype(FN_GT, 5'd3, 5'd2, 5'd1), {31'd0, b_val > a_val});
		alu_check(rtype(FN_GET, 5'd3, 5'd1, 5'd2), {31'd0, a_val >= b_val});
		alu_check(rtype(FN_LAND, 5'd3, 5'd1, 5'd0), 32'd0);
		alu_check(rtype(FN_LOR, 5'd3, 5'd1, 5'd0), 32'd1);
		plain(itype(OP_JF, 5'd0, 5'd1, 16'd200));	// r1 is true, falls through
		plain(itype(OP_JF, 5'd0, 5'd0, 16'd80));
		at = 80;
		plain(jtype(OP_J, 26'd90));
		at = 90;
		plain(jtype(OP_JAL, 26'd120));
		at = 120;
		show(5'd31, 32'd91);	// Link is the jal address plus one
		plain(rtype(FN_JR, 5'd0, 5'd31, 5'd0));
		at = 91;
		push(itype(OP_SW, 5'd1, 5'd2, 16'd3), 1'b0, 1'b1, 1'b0, b_val + 32'd3, a_val);
		plain(itype(OP_LW, 5'd5, 5'd0, 16'd10));
		show(5'd5, a_val);
		plain(itype(OP_IN, 5'd6, 5'd0, 16'd0));
		push(itype(OP_OUT, 5'd0, 5'd6, 16'd0), 1'b1, 1'b0, 1'b1, '0, '0);
		plain(itype(OP_LI, 5'd0, 5'd0, 16'd55));	// r0 must stay zero
		show(5'd0, 32'd0);
		plain(jtype(OP_HALT, 26'd0));
	endtask

	task automatic check_data(input string what, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: pc is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic drive_inputs;
		i_instr    = prog[o_pc[7:0]];
		rand_state = lcg(rand_state);
		i_in_data  = rand_state;
	endtask

	task automatic check_step(input step_t st);
		check_pc(o_pc, st.pc);
		check_flag("halted", o_halted, 1'b0);
		check_flag("out valid", o_out_valid, st.is_out);
		check_flag("mem write", o_mem_we, st.is_store);
		if (st.is_out)
			check_data("out data", o_out_data, st.from_in ? in_seen : st.value);
		if (st.is_store) begin
			check_data("mem addr", o_mem_addr, st.addr);
			check_data("mem data", o_mem_wdata, st.value);
		end
		if (st.instr.i.op == OP_IN)
			in_seen = i_in_data;	// Value the core writes at the next edge
	endtask

	task automatic record_store;
		if (o_mem_we)
			dmem[o_mem_addr[5:0]] = o_mem_wdata;
	endtask

	// Ends a run that never reaches halt
	always @(posedge i_clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the core did not halt within %0d cycles", limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		i_rst      = 1'b1;
		i_instr    = '0;
		i_in_data  = '0;
		rand_state = 32'd97;
		in_seen    = '0;
		a_val      = 32'd100;
		b_val      = 32'd7;
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		for (int k = 0; k < 64; k++)
			dmem[k] = 32'hD000_0000 | (k * 32'h0001_0001);
		for (int k = 0; k < 256; k++)
			prog[k] = '0;
		build_program();
		foreach (steps[n])
			prog[steps[n].pc[7:0]] = steps[n].instr;
		halt_pc = steps[steps.size()-1].pc;
		limit   = steps.size() + 20;

		repeat (3) @(posedge i_clk);
		foreach (steps[n]) begin
			@(negedge i_clk);
			i_rst = 1'b0;
			drive_inputs();
			#1;
			check_step(steps[n]);
			record_store();
		end

		waited = 0;
		while (!o_halted) begin
			@(negedge i_clk);
			drive_inputs();
			waited++;
		end
		check_data("halt latency", waited, 32'd1);
		for (int k = 0; k < 4; k++) begin
			@(negedge i_clk);
			drive_inputs();
			// Strobing instructions while halted must stay masked
			if (k[0])
				i_instr = itype(OP_OUT, 5'd0, 5'd1, 16'd0);
			else
				i_instr = itype(OP_SW, 5'd1, 5'd2, 16'd3);
			#1;
			check_pc(o_pc, halt_pc);
			check_flag("mem write after halt", o_mem_we, 1'b0);
			check_flag("out valid after halt", o_out_valid, 1'b0);
		end
		check_flag("halted", o_halted, 1'b1);

		errors += dut0.props0.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/pc_unit.sv
rtl/cpu_core.sv
testbench/cpu_core_props.sv
testbench/cpu_core_tb.sv
